// File: sim.f
+incdir+bench
rtl/bp_pkg.sv
rtl/local_history_predictor.sv
rtl/gshare_predictor.sv
rtl/tournament_chooser.sv
rtl/predict_response.sv
rtl/branch_predictor.sv
bench/tb_branch_predictor.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the branch predictor testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_branch_predictor

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module "$TOP" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: bench/bp_model.svh
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

logic [5:0]  m_hist [32];       // Local history per pc[6:2]
logic [1:0]  m_lctr [2048];     // Indexed by {history, pc[6:2]}
logic [7:0]  m_ghr;
logic [1:0]  m_gctr [256];
logic [1:0]  m_chs  [32];       // Upper bit set selects global
logic [31:0] lfsr_state = 32'h637b;

function automatic logic [1:0] sat_step(logic [1:0] c, logic up);
    if (up) return (c == 2'b11) ? c : c + 2'b01;
    return (c == 2'b00) ? c : c - 2'b01;
endfunction

task automatic model_reset();
    m_ghr = '0;
    for (int i = 0; i < 32; i++) begin
        m_hist[i] = '0;
        m_chs[i]  = 2'b00;
    end
    for (int i = 0; i < 2048; i++) begin
        m_lctr[i] = 2'b00;
    end
    for (int i = 0; i < 256; i++) begin
        m_gctr[i] = 2'b00;
    end
endtask

// Expected {final, local, global, global chosen}
function automatic logic [3:0] model_predict(logic [31:0] pc);
    logic [4:0] idx;
    logic       l;
    logic       g;
    logic       p;
    idx = pc[6:2];
    l   = m_lctr[{m_hist[idx], idx}][1];
    g   = m_gctr[pc[9:2] ^ m_ghr][1];
    p   = m_chs[idx][1];
    return {p ? g : l, l, g, p};
endfunction

task automatic model_update(logic [31:0] pc, logic taken);
    logic [4:0]  idx;
    logic [10:0] li;
    logic [7:0]  gi;
    idx = pc[6:2];
    li  = {m_hist[idx], idx};
    gi  = pc[9:2] ^ m_ghr;      // Hashed with the history before the shift
    if (m_lctr[li][1] != m_gctr[gi][1]) begin
        m_chs[idx] = sat_step(m_chs[idx], m_gctr[gi][1] == taken);
    end
    m_lctr[li]  = sat_step(m_lctr[li], taken);
    m_gctr[gi]  = sat_step(m_gctr[gi], taken);
    m_hist[idx] = {m_hist[idx][4:0], taken};
    m_ghr       = {m_ghr[6:0], taken};
endtask

// Fibonacci LFSR with taps 32 22 2 1 stepped once for every bit returned
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        r          = {r[30:0], fb};
    end
    return r;
endfunction

`endif

// File: bench/tb_branch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module tb_branch_predictor;
    import bp_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic [31:0] req_pc;
    logic        req_ready;
    logic        resp_valid;
    logic        resp_ready;
    logic        resp_taken;
    logic        resp_local_taken;
    logic        resp_global_taken;
    provider_t   resp_provider;
    logic        upd_valid;
    logic [31:0] upd_pc;
    logic        upd_taken;

    logic [3:0]  expect_q [$];     // One entry per accepted request
    int          n_accepted;
    int          n_consumed;
    logic        stall_mode;
    int          stall_left;

    `include "bp_model.svh"

    branch_predictor UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting and driving
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_error(string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic next_ready();
        if (!stall_mode) return 1'b1;
        if (stall_left > 0) begin
            stall_left--;
            return 1'b0;
        end
        if (rand_bits(2) == 0) begin
            stall_left = rand_bits(3);    // Stretch of one to eight cycles
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // One driven cycle that repeats while the request waits for req_ready
    task automatic drive(logic rv, logic [31:0] pc, logic uv, logic [31:0] upc, logic ut);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        req_valid  = rv;
        req_pc     = pc;
        upd_valid  = uv;
        upd_pc     = upc;
        upd_taken  = ut;
        resp_ready = next_ready();
        forever begin
            @(negedge clk);
            // Tables still hold their state from before the coming edge
            if (req_valid && req_ready) begin
                expect_q.push_back(model_predict(req_pc));
                n_accepted++;
            end
            if (upd_valid) model_update(upd_pc, upd_taken);
            if (!req_valid || req_ready) break;
            waited++;
            if (waited > 50) stop_with_error("request was not accepted within 50 cycles");
            @(posedge clk);
            #1;
            upd_valid  = 1'b0;
            resp_ready = next_ready();
        end
    endtask

    task automatic random_cycle();
        logic        rv;
        logic        uv;
        logic        ut;
        logic [31:0] pc;
        logic [31:0] upc;
        rv  = 1'(rand_bits(1));
        pc  = 32'h1000 + (rand_bits(3) << 3);    // A small set whose low gshare bits alias
        uv  = 1'(rand_bits(1));
        upc = 32'h1000 + (rand_bits(3) << 3);
        ut  = 1'(rand_bits(1));
        drive(rv, pc, uv, upc, ut);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Response checker
    //////////////////////////////////////////////////////////////////////

    initial begin : resp_checker
        logic [3:0] exp;
        logic [3:0] held;
        logic       stalled;
        logic       accepted;
        stalled  = 1'b0;
        accepted = 1'b0;
        held     = '0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                // A response follows each accepted request and stays until it is consumed
                check("resp_valid", resp_valid, accepted || stalled);
                if (stalled) begin
                    check("held response", {resp_taken, resp_local_taken,
                          resp_global_taken, resp_provider}, held);
                end
                stalled  = resp_valid && !resp_ready;
                accepted = req_valid && req_ready;
                held     = {resp_taken, resp_local_taken, resp_global_taken, resp_provider};
                check("req_ready", req_ready, !stalled);
                if (resp_valid && resp_ready) begin
                    if (expect_q.size() == 0) begin
                        stop_with_error("a response arrived with no request outstanding");
                    end
                    exp = expect_q.pop_front();
                    check("resp_taken", resp_taken, exp[3]);
                    check("resp_local_taken", resp_local_taken, exp[2]);
                    check("resp_global_taken", resp_global_taken, exp[1]);
                    check("resp_provider", resp_provider,
                          exp[0] ? provider_global : provider_local);
                    n_consumed++;
                end
            end
        end
    end

    initial begin
        int waited;
        req_valid  = 1'b0;
        req_pc     = '0;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        resp_ready = 1'b1;
        rst_n      = 1'b0;
        stall_mode = 1'b0;
        stall_left = 0;
        n_accepted = 0;
        n_consumed = 0;
        model_reset();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < 4; i++) begin
            drive(1'b1, 32'h100 + i * 32'h44, 1'b0, '0, 1'b0);    // Cold tables
        end
        for (int i = 0; i < 20; i++) begin
            drive(1'b1, 32'h40, 1'b1, 32'h40, 1'b1);
        end
        drive(1'b1, 32'h40, 1'b0, '0, 1'b0);
        check("trained prediction", model_predict(32'h40), 4'b1110);

        // Local history separates the two phases of an alternating branch
        for (int i = 0; i < 40; i++) begin
            drive(1'b1, 32'h88, 1'b1, 32'h88, i[0]);
        end
        for (int i = 0; i < 300; i++) begin
            random_cycle();
        end
        stall_mode = 1'b1;
        for (int i = 0; i < 300; i++) begin
            random_cycle();
        end
        stall_mode = 1'b0;

        waited = 0;
        drive(1'b0, '0, 1'b0, '0, 1'b0);
        while (resp_valid) begin
            drive(1'b0, '0, 1'b0, '0, 1'b0);
            waited++;
            if (waited > 50) stop_with_error("responses were not drained within 50 cycles");
        end
        repeat (3) drive(1'b0, '0, 1'b0, '0, 1'b0);    // A stray response would show here

        if (n_accepted == n_consumed) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_error($sformatf("FAILED response count: got 0x%0h, expected 0x%0h",
                                      n_consumed, n_accepted));
        end
    end

endmodule

`default_nettype wire

// File: rtl/branch_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module branch_predictor (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                req_valid,
    input  wire [31:0]         req_pc,
    output logic               req_ready,
    output logic               resp_valid,
    input  wire                resp_ready,
    output logic               resp_taken,
    output logic               resp_local_taken,
    output logic               resp_global_taken,
    output bp_pkg::provider_t  resp_provider,
    input  wire                upd_valid,
    input  wire [31:0]         upd_pc,
    input  wire                upd_taken
);
    import bp_pkg::*;

    logic      lk_local_taken;
    logic      lk_global_taken;
    provider_t lk_provider;
    logic      upd_local_taken;    // Component views of the resolving branch
    logic      upd_global_taken;

    //////////////////////////////////////////////////////////////////////
    // Direction tables
    //////////////////////////////////////////////////////////////////////

    local_history_predictor u_local (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_pc      (req_pc),
        .lookup_taken   (lk_local_taken),
        .upd_valid      (upd_valid),
        .upd_pc         (upd_pc),
        .upd_taken      (upd_taken),
        .upd_pred_taken (upd_local_taken)
    );

    gshare_predictor u_gshare (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_pc      (req_pc),
        .lookup_taken   (lk_global_taken),
        .upd_valid      (upd_valid),
        .upd_pc         (upd_pc),
        .upd_taken      (upd_taken),
        .upd_pred_taken (upd_global_taken)
    );

    tournament_chooser u_chooser (
        .clk              (clk),
        .rst_n            (rst_n),
        .lookup_pc        (req_pc),
        .lookup_provider  (lk_provider),
        .upd_valid        (upd_valid),
        .upd_pc           (upd_pc),
        .upd_taken        (upd_taken),
        .upd_local_taken  (upd_local_taken),
        .upd_global_taken (upd_global_taken)
    );

    //////////////////////////////////////////////////////////////////////
    // Response register
    //////////////////////////////////////////////////////////////////////

    predict_response u_resp (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_valid         (req_valid),
        .req_ready         (req_ready),
        .local_taken       (lk_local_taken),
        .global_taken      (lk_global_taken),
        .provider          (lk_provider),
        .resp_valid        (resp_valid),
        .resp_ready        (resp_ready),
        .resp_taken        (resp_taken),
        .resp_local_taken  (resp_local_taken),
        .resp_global_taken (resp_global_taken),
        .resp_provider     (resp_provider)
    );

endmodule

`default_nettype wire

// File: rtl/predict_response.sv
`timescale 1ns/1ns
`default_nettype none

module predict_response (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                req_valid,
    output logic               req_ready,
    input  wire                local_taken,
    input  wire                global_taken,
    input  bp_pkg::provider_t  provider,
    output logic               resp_valid,
    input  wire                resp_ready,
    output logic               resp_taken,
    output logic               resp_local_taken,
    output logic               resp_global_taken,
    output bp_pkg::provider_t  resp_provider
);
    import bp_pkg::*;

    logic accept;

    // Free slot, or the held result leaves on this same edge
    assign req_ready = !resp_valid || resp_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (accept) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_taken        <= (provider == provider_global) ? global_taken : local_taken;
            resp_local_taken  <= local_taken;
            resp_global_taken <= global_taken;
            resp_provider     <= provider;
        end
    end

    // Back-pressure holds the whole response in place
    a_resp_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid
            && $stable({resp_taken, resp_local_taken, resp_global_taken, resp_provider})
    ) else $error("response changed while stalled");

endmodule

`default_nettype wire

// File: rtl/tournament_chooser.sv
`timescale 1ns/1ns
`default_nettype none

module tournament_chooser (
    input  wire                clk,
    input  wire                rst_n,
    input  wire [31:0]         lookup_pc,
    output bp_pkg::provider_t  lookup_provider,
    input  wire                upd_valid,
    input  wire [31:0]         upd_pc,
    input  wire                upd_taken,
    input  wire                upd_local_taken,
    input  wire                upd_global_taken
);
    import bp_pkg::*;

    ctr_t ctrs [local_entries];    // Counting up favours global

    logic [pc_idx_bits-1:0] lk_idx;
    logic [pc_idx_bits-1:0] up_idx;
    logic                   disagree;
    logic                   global_right;

    assign lk_idx = lookup_pc[pc_idx_bits+1:2];
    assign up_idx = upd_pc[pc_idx_bits+1:2];

    assign lookup_provider = ctrs[lk_idx][1] ? provider_global : provider_local;

    // Only a disagreement tells us anything about which side to trust
    assign disagree     = upd_local_taken != upd_global_taken;
    assign global_right = upd_global_taken == upd_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < local_entries; i++) begin
                ctrs[i] <= strong_not_taken;
            end
        end else if (upd_valid && disagree) begin
            ctrs[up_idx] <= ctr_next(ctrs[up_idx], global_right);
        end
    end

endmodule

`default_nettype wire

// File: rtl/gshare_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module gshare_predictor (
    input  wire        clk,
    input  wire        rst_n,
    input  wire [31:0] lookup_pc,
    output logic       lookup_taken,
    input  wire        upd_valid,
    input  wire [31:0] upd_pc,
    input  wire        upd_taken,
    output logic       upd_pred_taken
);
    import bp_pkg::*;

    logic [ghr_bits-1:0] ghr;
    ctr_t                ctrs [gshare_entries];

    logic [ghr_bits-1:0] lk_idx;
    logic [ghr_bits-1:0] up_idx;
    ctr_t                up_ctr;

    // Both sides hash with the history as it stands before the edge
    assign lk_idx = lookup_pc[ghr_bits+1:2] ^ ghr;
    assign up_idx = upd_pc[ghr_bits+1:2] ^ ghr;

    assign up_ctr         = ctrs[up_idx];
    assign lookup_taken   = ctrs[lk_idx][1];
    assign upd_pred_taken = up_ctr[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ghr <= '0;
            for (int i = 0; i < gshare_entries; i++) begin
                ctrs[i] <= strong_not_taken;
            end
        end else if (upd_valid) begin
            ctrs[up_idx] <= ctr_next(up_ctr, upd_taken);
            ghr          <= {ghr[ghr_bits-2:0], upd_taken};    // Newest outcome in bit 0
        end
    end

endmodule

`default_nettype wire

// File: rtl/local_history_predictor.sv
`timescale 1ns/1ns
`default_nettype none

module local_history_predictor (
    input  wire        clk,
    input  wire        rst_n,
    input  wire [31:0] lookup_pc,
    output logic       lookup_taken,
    input  wire        upd_valid,
    input  wire [31:0] upd_pc,
    input  wire        upd_taken,
    output logic       upd_pred_taken
);
    import bp_pkg::*;

    logic [local_hist_bits-1:0] hist [local_entries];    // Per-branch shift history
    ctr_t                       ctrs [local_ctr_entries];

    logic [pc_idx_bits-1:0]    lk_idx;
    logic [pc_idx_bits-1:0]    up_idx;
    logic [local_ctr_bits-1:0] lk_ctr_idx;
    logic [local_ctr_bits-1:0] up_ctr_idx;
    ctr_t                      up_ctr;

    assign lk_idx = lookup_pc[pc_idx_bits+1:2];
    assign up_idx = upd_pc[pc_idx_bits+1:2];

    // History sits above the pc bits in the counter index
    assign lk_ctr_idx = {hist[lk_idx], lk_idx};
    assign up_ctr_idx = {hist[up_idx], up_idx};

    assign up_ctr         = ctrs[up_ctr_idx];
    assign lookup_taken   = ctrs[lk_ctr_idx][1];
    assign upd_pred_taken = up_ctr[1];              // Seen by the chooser before the edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < local_entries; i++) begin
                hist[i] <= '0;
            end
            for (int i = 0; i < local_ctr_entries; i++) begin
                ctrs[i] <= strong_not_taken;
            end
        end else if (upd_valid) begin
            ctrs[up_ctr_idx] <= ctr_next(up_ctr, upd_taken);
            hist[up_idx]     <= {hist[up_idx][local_hist_bits-2:0], upd_taken};
        end
    end

    // A resolved branch must carry a real outcome into both history and counter
    a_upd_taken_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        upd_valid |-> !$isunknown(upd_taken)
    ) else $error("upd_taken unknown on a valid update");

endmodule

`default_nettype wire

// File: rtl/bp_pkg.sv
`default_nettype none

package bp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Table geometry
    //////////////////////////////////////////////////////////////////////

    localparam int pc_idx_bits       = 5;                  // pc[6:2]
    localparam int local_hist_bits   = 6;
    localparam int ghr_bits          = 8;                  // Also the gshare pc slice, pc[9:2]
    localparam int local_ctr_bits    = local_hist_bits + pc_idx_bits;
    localparam int local_entries     = 2 ** pc_idx_bits;
    localparam int local_ctr_entries = 2 ** local_ctr_bits;
    localparam int gshare_entries    = 2 ** ghr_bits;

    //////////////////////////////////////////////////////////////////////
    // Shared types
    //////////////////////////////////////////////////////////////////////

    // Upper bit set means taken (or global, for the chooser)
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } ctr_t;

    typedef enum logic {
        provider_local  = 1'b0,
        provider_global = 1'b1
    } provider_t;

    // Saturating step, up on taken and down otherwise
    function automatic ctr_t ctr_next(ctr_t c, logic taken);
        ctr_t n;
        case (c)
            strong_not_taken: n = taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   n = taken ? weak_taken     : strong_not_taken;
            weak_taken:       n = taken ? strong_taken   : weak_not_taken;
            default:          n = taken ? strong_taken   : weak_taken;
        endcase
        return n;
    endfunction

endpackage

`default_nettype wire
